/* source/miniCore_config.svh */
`ifndef MINICORE_CONFIG_SVH
`define MINICORE_CONFIG_SVH

`define DATA_WIDTH          32
`define REG_ADDR_WIDTH      5
`define RESET_SETTLE_CYCLES 3
`define DECODE_CYCLES       4
`define REG_WRITE_CYCLES    1
`define PC_WRITE_CYCLES     1
`define MUL_CYCLES          9
`define DIV_CYCLES          7
`define MOD_CYCLES          9
`define LINK_REGISTER       31

`endif

/* source/isaPkg.sv */
`default_nettype none

`include "miniCore_config.svh"

package isaPkg;

    // Primary opcode in bits 31:26
    typedef enum logic [5:0] {
        opAlu   = 6'h00,
        opJump  = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLoad  = 6'h23,
        opStore = 6'h2b
    } opcodeT;

    // Function code in bits 5:0 of register-register words
    typedef enum logic [5:0] {
        fnMul = 6'h18,
        fnDiv = 6'h1a,
        fnMod = 6'h1b,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT                     opcode;
        functT                      funct;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                immediate;
        logic [25:0]                jumpTarget;
    } decodedInstrT;

endpackage

`default_nettype wire

/* source/controlPkg.sv */
`default_nettype none

package controlPkg;

    typedef enum logic [3:0] {
        stReset,
        stFetch,
        stDecode,
        stExecute,
        stAluWrite,
        stWbJump,
        stWbStore,
        stWbLoad,
        stWbReg
    } seqStateT;

    // Levels from the sequencer to the datapath and the memory ports
    typedef struct packed {
        logic regWrite;
        logic aluStart;
        logic aluWrite;
        logic fetchRequest;
        logic loadRequest;
        logic storeRequest;
        logic pcWrite;
        logic decode;
    } controlStrobesT;

endpackage

`default_nettype wire

/* source/controlUnit.sv */
`default_nettype none

`include "miniCore_config.svh"

module controlUnit (
    input  logic                       Clock,
    input  logic                       arstN,
    input  isaPkg::decodedInstrT       instr,
    input  logic                       instrReady,
    input  logic                       loadDone,
    input  logic                       storeDone,
    output controlPkg::controlStrobesT strobes
);
    import isaPkg::*;
    import controlPkg::*;

    localparam int CountWidth = 8;

    seqStateT              state;
    logic [CountWidth-1:0] count;
    logic                  countDone;

    // Execute length by function code; non-ALU words arrive as fnAdd
    function automatic logic [CountWidth-1:0] executeCycles(functT funct);
        case (funct)
            fnMul:   return CountWidth'(`MUL_CYCLES);
            fnDiv:   return CountWidth'(`DIV_CYCLES);
            fnMod:   return CountWidth'(`MOD_CYCLES);
            default: return CountWidth'(1);
        endcase
    endfunction

    assign countDone = (count == '0);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state <= stReset;
            count <= CountWidth'(`RESET_SETTLE_CYCLES);
        end else begin
            case (state)
                stReset: begin
                    // Settle time before the first fetch
                    if (countDone) begin
                        state <= stFetch;
                    end else begin
                        count <= count - CountWidth'(1);
                    end
                end
                stFetch: begin
                    if (instrReady) begin
                        state <= stDecode;
                        count <= CountWidth'(`DECODE_CYCLES - 1);
                    end
                end
                stDecode: begin
                    if (countDone) begin
                        state <= stExecute;
                        count <= executeCycles(instr.funct) - CountWidth'(1);
                    end else begin
                        count <= count - CountWidth'(1);
                    end
                end
                stExecute: begin
                    if (countDone) begin
                        state <= stAluWrite;
                    end else begin
                        count <= count - CountWidth'(1);
                    end
                end
                stAluWrite: begin
                    // Writeback path by opcode
                    case (instr.opcode)
                        opJump, opJal, opBeq: begin
                            state <= stWbJump;
                            count <= CountWidth'(`PC_WRITE_CYCLES - 1);
                        end
                        opStore: state <= stWbStore;
                        opLoad:  state <= stWbLoad;
                        default: begin
                            state <= stWbReg;
                            count <= CountWidth'(`REG_WRITE_CYCLES - 1);
                        end
                    endcase
                end
                stWbLoad: begin
                    if (loadDone) begin
                        state <= stWbReg;
                        count <= CountWidth'(`REG_WRITE_CYCLES - 1);
                    end
                end
                stWbStore: begin
                    if (storeDone) begin
                        state <= stFetch;
                    end
                end
                stWbJump, stWbReg: begin
                    if (countDone) begin
                        state <= stFetch;
                    end else begin
                        count <= count - CountWidth'(1);
                    end
                end
                default: state <= stFetch;
            endcase
        end
    end

    always_comb begin
        strobes.fetchRequest = (state == stFetch);
        strobes.decode       = (state == stDecode);
        strobes.aluStart     = (state == stExecute);
        strobes.aluWrite     = (state == stAluWrite);
        strobes.loadRequest  = (state == stWbLoad);
        strobes.storeRequest = (state == stWbStore);
        // Link register is written while jal executes
        strobes.regWrite     = (state == stWbReg)
                             || (state == stExecute && instr.opcode == opJal);
        // High in the final writeback cycle only
        strobes.pcWrite      = ((state == stWbJump || state == stWbReg) && countDone)
                             || (state == stWbStore && storeDone);
    end

endmodule

`default_nettype wire

/* source/instructionDecoder.sv */
`default_nettype none

`include "miniCore_config.svh"

module instructionDecoder (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic [`DATA_WIDTH-1:0] instrData,
    input  logic                   instrReady,
    output isaPkg::decodedInstrT   instr
);
    import isaPkg::*;

    decodedInstrT fields;

    always_comb begin
        fields.opcode     = opcodeT'(instrData[31:26]);
        fields.rs         = instrData[25:21];
        fields.rt         = instrData[20:16];
        fields.rd         = instrData[15:11];
        fields.immediate  = instrData[15:0];
        fields.jumpTarget = instrData[25:0];
        // Address and immediate sums go through the adder
        if (fields.opcode == opAlu) begin
            fields.funct = functT'(instrData[5:0]);
        end else begin
            fields.funct = fnAdd;
        end
    end

    // Held until the next fetch completes
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            instr <= '0;
        end else if (instrReady) begin
            instr <= fields;
        end
    end

endmodule

`default_nettype wire

/* source/executionUnit.sv */
`default_nettype none

`include "miniCore_config.svh"

module executionUnit (
    input  logic                       Clock,
    input  logic                       arstN,
    input  isaPkg::decodedInstrT       instr,
    input  logic [`DATA_WIDTH-1:0]     operandA,
    input  logic [`DATA_WIDTH-1:0]     operandB,
    input  controlPkg::controlStrobesT strobes,
    output logic [`DATA_WIDTH-1:0]     result,
    output logic                       branchTaken
);
    import isaPkg::*;

    logic [`DATA_WIDTH-1:0] immExtended;
    logic [`DATA_WIDTH-1:0] secondOperand;
    logic [`DATA_WIDTH-1:0] aluValue;

    assign immExtended = {{(`DATA_WIDTH-16){instr.immediate[15]}}, instr.immediate};

    always_comb begin
        case (instr.opcode)
            opAddi, opLoad, opStore: secondOperand = immExtended;
            default:                 secondOperand = operandB;
        endcase
    end

    always_comb begin
        case (instr.funct)
            fnSub:   aluValue = operandA - secondOperand;
            fnAnd:   aluValue = operandA & secondOperand;
            fnOr:    aluValue = operandA | secondOperand;
            fnSlt:   aluValue = {{(`DATA_WIDTH-1){1'b0}},
                                 ($signed(operandA) < $signed(secondOperand))};
            fnMul:   aluValue = operandA * secondOperand;
            // Divide by zero gives all ones, modulo by zero the dividend
            fnDiv:   aluValue = (secondOperand == '0) ? '1 : operandA / secondOperand;
            fnMod:   aluValue = (secondOperand == '0) ? operandA : operandA % secondOperand;
            default: aluValue = operandA + secondOperand;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            result      <= '0;
            branchTaken <= 1'b0;
        end else if (strobes.aluWrite) begin
            result      <= aluValue;
            branchTaken <= (instr.opcode == opBeq) && (operandA == operandB);
        end
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none

`include "miniCore_config.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic                       writeEnable,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB
);
    localparam int RegCount = 1 << `REG_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] registers [RegCount];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < RegCount; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            registers[writeAddr] <= writeData;
        end
    end

    // Register 0 is hardwired to zero
    assign readDataA = (readAddrA == '0) ? '0 : registers[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : registers[readAddrB];

endmodule

`default_nettype wire

/* source/miniCore.sv */
`default_nettype none

`include "miniCore_config.svh"

module miniCore (
    input  logic                   Clock,
    input  logic                   arstN,
    output logic                   instrRequest,
    output logic [`DATA_WIDTH-1:0] instrAddress,
    input  logic                   instrReady,
    input  logic [`DATA_WIDTH-1:0] instrData,
    output logic                   loadRequest,
    output logic                   storeRequest,
    output logic [`DATA_WIDTH-1:0] dataAddress,
    output logic [`DATA_WIDTH-1:0] storeData,
    input  logic                   loadDone,
    input  logic                   storeDone,
    input  logic [`DATA_WIDTH-1:0] loadData
);
    import isaPkg::*;
    import controlPkg::*;

    localparam int DataWidth    = `DATA_WIDTH;
    localparam int RegAddrWidth = `REG_ADDR_WIDTH;
    localparam logic [RegAddrWidth-1:0] LinkAddr = RegAddrWidth'(`LINK_REGISTER);

    controlStrobesT          strobes;
    decodedInstrT            instr;
    logic [DataWidth-1:0]    pc;
    logic [DataWidth-1:0]    pcPlusOne;
    logic [DataWidth-1:0]    pcNext;
    logic [DataWidth-1:0]    branchOffset;
    logic [DataWidth-1:0]    loadWord;
    logic [DataWidth-1:0]    operandA;
    logic [DataWidth-1:0]    operandB;
    logic [DataWidth-1:0]    result;
    logic [DataWidth-1:0]    writeData;
    logic [RegAddrWidth-1:0] writeAddr;
    logic                    branchTaken;
    logic                    jumpSelect;

    assign pcPlusOne    = pc + DataWidth'(1);
    assign branchOffset = {{(DataWidth-16){instr.immediate[15]}}, instr.immediate};

    assign jumpSelect = (instr.opcode == opJump) || (instr.opcode == opJal)
                      || (instr.opcode == opBeq && branchTaken);

    always_comb begin
        if (!jumpSelect) begin
            pcNext = pcPlusOne;
        end else if (instr.opcode == opBeq) begin
            // Branch targets are relative to the following word
            pcNext = pcPlusOne + branchOffset;
        end else begin
            pcNext = {{(DataWidth-26){1'b0}}, instr.jumpTarget};
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (strobes.pcWrite) begin
            pc <= pcNext;
        end
    end

    // Load data is kept for the register write after loadDone
    always_ff @(posedge Clock) begin
        if (loadDone) begin
            loadWord <= loadData;
        end
    end

    always_comb begin
        if (instr.opcode == opJal) begin
            writeAddr = LinkAddr;
            writeData = pcPlusOne;
        end else if (instr.opcode == opAlu) begin
            writeAddr = instr.rd;
            writeData = result;
        end else begin
            writeAddr = instr.rt;
            writeData = (instr.opcode == opLoad) ? loadWord : result;
        end
    end

    assign instrRequest = strobes.fetchRequest;
    assign instrAddress = pc;
    assign loadRequest  = strobes.loadRequest;
    assign storeRequest = strobes.storeRequest;
    assign dataAddress  = result;
    assign storeData    = operandB;

    controlUnit sequencer (
        .Clock      (Clock),
        .arstN      (arstN),
        .instr      (instr),
        .instrReady (instrReady),
        .loadDone   (loadDone),
        .storeDone  (storeDone),
        .strobes    (strobes)
    );

    instructionDecoder decoder (
        .Clock      (Clock),
        .arstN      (arstN),
        .instrData  (instrData),
        .instrReady (instrReady),
        .instr      (instr)
    );

    executionUnit execute (
        .Clock       (Clock),
        .arstN       (arstN),
        .instr       (instr),
        .operandA    (operandA),
        .operandB    (operandB),
        .strobes     (strobes),
        .result      (result),
        .branchTaken (branchTaken)
    );

    registerFile registers (
        .Clock       (Clock),
        .arstN       (arstN),
        .readAddrA   (instr.rs),
        .readAddrB   (instr.rt),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .writeEnable (strobes.regWrite),
        .readDataA   (operandA),
        .readDataB   (operandB)
    );

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`default_nettype none

module clockGen (
    output logic Clock,
    output logic arstN
);
    initial Clock = 1'b0;
    always #20 Clock = ~Clock;

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (8) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;
    end
endmodule

`default_nettype wire

/* bench/miniCore_checker.sv */
`default_nettype none

`include "miniCore_config.svh"

module miniCore_checker (
    input logic                   Clock,
    input logic                   arstN,
    input logic                   instrRequest,
    input logic                   instrReady,
    input logic [`DATA_WIDTH-1:0] instrAddress,
    input logic                   loadRequest,
    input logic                   loadDone,
    input logic                   storeRequest,
    input logic                   storeDone,
    input logic [`DATA_WIDTH-1:0] dataAddress,
    input logic [`DATA_WIDTH-1:0] storeData
);
    logic violation = 1'b0;

    quietInReset: assert property (@(posedge Clock)
        !arstN |-> !(instrRequest || loadRequest || storeRequest))
        else begin $error("request high during reset"); violation = 1'b1; end

    oneRequest: assert property (@(posedge Clock) disable iff (!arstN)
        $onehot0({instrRequest, loadRequest, storeRequest}))
        else begin $error("more than one request high"); violation = 1'b1; end

    // Requests hold with stable address and data until done
    fetchHeld: assert property (@(posedge Clock) disable iff (!arstN)
        instrRequest && !instrReady |=> instrRequest && $stable(instrAddress))
        else begin $error("fetch request dropped or changed"); violation = 1'b1; end

    loadHeld: assert property (@(posedge Clock) disable iff (!arstN)
        loadRequest && !loadDone |=> loadRequest && $stable(dataAddress))
        else begin $error("load request dropped or changed"); violation = 1'b1; end

    storeHeld: assert property (@(posedge Clock) disable iff (!arstN)
        storeRequest && !storeDone |=> storeRequest && $stable(dataAddress)
        && $stable(storeData))
        else begin $error("store request dropped or changed"); violation = 1'b1; end
endmodule

`default_nettype wire

/* bench/miniCoreTb.sv */
`default_nettype none

`include "miniCore_config.svh"

module miniCoreTb;
    import isaPkg::*;

    localparam int MemWords = 64;

    logic        Clock, arstN;
    logic        instrRequest, instrReady, loadRequest, storeRequest, loadDone, storeDone;
    logic [31:0] instrAddress, instrData, dataAddress, storeData, loadData;
    logic [31:0] instrMem [MemWords];
    logic [31:0] dataMem [MemWords];
    logic [31:0] modelMem [MemWords];
    logic [31:0] expFetch[$];
    logic [31:0] expStoreAddr[$];
    logic [31:0] expStoreData[$];
    logic [31:0] readyWord;
    logic        prevRequest = 1'b0;
    bit          done = 1'b0;
    bit          seeded = 1'b0;
    int          progLength = 0;
    int          fetchWait = -1;
    int          loadWait = -1;
    int          storeWait = -1;
    int          negCount = 0;
    int          readyMark = -1;
    int          waited;

    clockGen clocks (.Clock(Clock), .arstN(arstN));

    miniCore DUT (.*);

    bind miniCore miniCore_checker protocolCheck (.*);

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] rType(functT fn, int rd, int rs, int rt);
        return {6'(opAlu), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, int rs, int rt, int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jType(opcodeT op, int target);
        return {6'(op), 26'(target)};
    endfunction

    function automatic int latencyOf(logic [5:0] fn);
        case (functT'(fn))
            fnMul:   return `MUL_CYCLES;
            fnDiv:   return `DIV_CYCLES;
            fnMod:   return `MOD_CYCLES;
            default: return 1;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        instrMem[progLength] = word;
        progLength++;
    endtask

    task automatic loadProgram();
        functT fns [8];
        fns = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnMul, fnDiv, fnMod};
        for (int i = 0; i < MemWords; i++) begin
            instrMem[i] = '0;
            dataMem[i]  = 32'h3c00_0000 + 32'(i) * 32'h0001_0203;
        end
        emit(iType(opAddi, 0, 1, -100));
        emit(iType(opAddi, 0, 2, 9));
        emit(iType(opStore, 0, 1, 0));
        foreach (fns[i]) begin
            emit(rType(fns[i], 4, 1, 2));
            emit(iType(opStore, 0, 4, 1 + i));
        end
        // r3 is still zero
        emit(rType(fnDiv, 4, 1, 3));
        emit(iType(opStore, 0, 4, 9));
        emit(rType(fnMod, 4, 1, 3));
        emit(iType(opStore, 0, 4, 10));
        emit(iType(opLoad, 0, 6, 40));
        emit(rType(fnAdd, 7, 6, 1));
        emit(iType(opStore, 0, 7, 11));
        // Taken beq skips one word, untaken falls through
        emit(iType(opBeq, 1, 1, 1));
        emit(iType(opAddi, 0, 8, 99));
        emit(iType(opBeq, 1, 2, 1));
        emit(iType(opAddi, 0, 9, 5));
        emit(jType(opJump, progLength + 2));
        emit(iType(opAddi, 0, 8, 55));
        emit(jType(opJal, progLength + 2));
        emit(iType(opAddi, 0, 9, 66));
        emit(iType(opStore, 0, 31, 12));
        emit(iType(opStore, 0, 8, 13));
        emit(iType(opStore, 0, 9, 14));
    endtask

    // Instruction-level model of the program
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc, next, w, a, b, imm, addr;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < MemWords; i++) modelMem[i] = dataMem[i];
        pc = '0;
        for (int step = 0; step < 200; step++) begin
            w = instrMem[pc[5:0]];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            next = pc + 32'd1;
            expFetch.push_back(pc);
            case (opcodeT'(w[31:26]))
                opAlu: begin
                    case (functT'(w[5:0]))
                        fnSub:   regs[w[15:11]] = a - b;
                        fnAnd:   regs[w[15:11]] = a & b;
                        fnOr:    regs[w[15:11]] = a | b;
                        fnSlt:   regs[w[15:11]] = {31'd0, $signed(a) < $signed(b)};
                        fnMul:   regs[w[15:11]] = a * b;
                        fnDiv:   regs[w[15:11]] = (b == '0) ? '1 : a / b;
                        fnMod:   regs[w[15:11]] = (b == '0) ? a : a % b;
                        default: regs[w[15:11]] = a + b;
                    endcase
                end
                opAddi: regs[w[20:16]] = addr;
                opLoad: regs[w[20:16]] = modelMem[addr[5:0]];
                opStore: begin
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(b);
                    modelMem[addr[5:0]] = b;
                end
                opBeq:  next = (a == b) ? pc + 32'd1 + imm : pc + 32'd1;
                opJump: next = {6'd0, w[25:0]};
                opJal: begin
                    regs[31] = pc + 32'd1;
                    next = {6'd0, w[25:0]};
                end
                default: ;
            endcase
            regs[0] = '0;
            if (pc == 32'(progLength - 1)) break;
            pc = next;
        end
    endtask

    always @(negedge Clock) begin
        // Seed the delay generator once
        if (!seeded) begin
            void'($urandom(32'hb783));
            seeded = 1'b1;
        end
        if (DUT.protocolCheck.violation) failRun("a protocol assertion failed");
        if (arstN) negCount++;
        // Restart gap counted from the end of the ready pulse
        if (instrReady) begin
            readyMark = negCount;
            readyWord = instrData;
        end
        if (instrRequest && !prevRequest && readyMark >= 0 && readyWord[31:26] == opAlu)
            assert (negCount - readyMark == `DECODE_CYCLES + latencyOf(readyWord[5:0])
                    + 1 + `REG_WRITE_CYCLES)
            else failRun($sformatf("[ERROR] ALU restart gap: expected %0d, actual %0d",
                `DECODE_CYCLES + latencyOf(readyWord[5:0]) + 1 + `REG_WRITE_CYCLES,
                negCount - readyMark));
        prevRequest = instrRequest;

        if (instrReady) begin
            instrReady = 1'b0;
        end else if (instrRequest && !done) begin
            if (fetchWait < 0) begin
                if (expFetch.size() == 0) failRun("fetch beyond the end of the program");
                assert (instrAddress == expFetch[0])
                else failRun($sformatf("[ERROR] fetch address: expected %0d, actual %0d",
                    expFetch[0], instrAddress));
                void'(expFetch.pop_front());
                fetchWait = int'($urandom % 6);
            end
            if (fetchWait == 0) begin
                instrReady = 1'b1;
                instrData  = instrMem[instrAddress[5:0]];
            end
            fetchWait--;
        end

        if (loadDone) begin
            loadDone = 1'b0;
        end else if (loadRequest) begin
            if (loadWait < 0) loadWait = int'($urandom % 6);
            if (loadWait == 0) begin
                loadDone = 1'b1;
                loadData = dataMem[dataAddress[5:0]];
            end
            loadWait--;
        end

        if (storeDone) begin
            storeDone = 1'b0;
        end else if (storeRequest && !done) begin
            if (storeWait < 0) storeWait = int'($urandom % 6);
            if (storeWait == 0) begin
                storeDone = 1'b1;
                assert (dataAddress == expStoreAddr[0])
                else failRun($sformatf("[ERROR] store address: expected %0d, actual %0d",
                    expStoreAddr[0], dataAddress));
                assert (storeData == expStoreData[0])
                else failRun($sformatf("[ERROR] store data: expected 0x%08h, actual 0x%08h",
                    expStoreData[0], storeData));
                dataMem[dataAddress[5:0]] = storeData;
                void'(expStoreAddr.pop_front());
                void'(expStoreData.pop_front());
                if (expStoreAddr.size() == 0) done = 1'b1;
            end
            storeWait--;
        end
    end

    initial begin
        instrReady  = 1'b0;
        instrData   = '0;
        loadDone    = 1'b0;
        storeDone   = 1'b0;
        loadData    = '0;
        loadProgram();
        runModel();
        waited = 0;
        while (arstN !== 1'b1) begin
            @(negedge Clock);
            waited++;
            if (waited > 50) failRun("reset was never released");
        end
        waited = 0;
        while (!done) begin
            @(negedge Clock);
            waited++;
            if (waited > 20000) failRun("timeout waiting for the final store");
        end
        if (!DUT.protocolCheck.violation) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failRun("a protocol assertion failed");
        end
    end
endmodule

`default_nettype wire

/* miniCore.f */
+incdir+source
source/isaPkg.sv
source/controlPkg.sv
source/controlUnit.sv
source/instructionDecoder.sv
source/executionUnit.sv
source/registerFile.sv
source/miniCore.sv
bench/clockGen.sv
bench/miniCore_checker.sv
bench/miniCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= miniCoreTb
FILELIST  ?= miniCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
